// ==== include/exu_defs.svh ====
// execute stage widths and special register numbers
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data and address width
`define EXU_XLEN        32

// register index width
`define EXU_REG_W       5

// x0 reads as zero and is never a forwarding source
`define EXU_ZERO_REG    5'd0

// link registers used to spot calls and returns
`define EXU_LINK_RA     5'd1
`define EXU_LINK_T0     5'd5

// control field widths
`define EXU_ALU_OP_W    4
`define EXU_RD_SEL_W    2
`define EXU_MEM_SIZE_W  3

`endif

// ==== source/exu_pkg.sv ====
// execute stage types shared by the pipeline blocks and the testbench
`include "exu_defs.svh"

package exu_pkg;

    typedef enum logic [`EXU_ALU_OP_W-1:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        // branch compares
        alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_op_e;

    typedef enum logic [`EXU_RD_SEL_W-1:0] {
        sel_alu, sel_pc_imm, sel_pc_plus, sel_imm
    } rd_sel_e;

    typedef struct packed {
        logic                       rf_we;
        rd_sel_e                    rd_sel;
        logic                       op2_imm;
        alu_op_e                    alu_op;
        logic                       mem_we;
        logic                       mem_re;
        logic [`EXU_MEM_SIZE_W-1:0] mem_size;
        logic                       is_branch;
        logic                       is_jal;
        logic                       is_jalr;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]  pc;
        logic [`EXU_XLEN-1:0]  pc_plus;
        logic [`EXU_REG_W-1:0] rs1;
        logic [`EXU_REG_W-1:0] rs2;
        logic [`EXU_REG_W-1:0] rd;
        // register file values read in decode
        logic [`EXU_XLEN-1:0]  rd1;
        logic [`EXU_XLEN-1:0]  rd2;
        logic [`EXU_XLEN-1:0]  imm;
        ex_ctrl_t              ctrl;
        // fetch predictor guess
        logic                  bp_taken;
        logic                  bp_match;
        logic [`EXU_XLEN-1:0]  bp_target;
    } ex_uop_t;

    typedef struct packed {
        logic                  we;
        logic [`EXU_REG_W-1:0] rd;
        logic [`EXU_XLEN-1:0]  data;
    } bypass_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]       pc;
        logic [`EXU_REG_W-1:0]      rd;
        logic                       rf_we;
        logic                       mem_we;
        logic                       mem_re;
        logic [`EXU_MEM_SIZE_W-1:0] mem_size;
        // result or memory address
        logic [`EXU_XLEN-1:0]       dout;
        logic [`EXU_XLEN-1:0]       store_data;
    } lsu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`EXU_XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                 valid;
        logic                 new_entry;
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] target;
        logic                 taken;
        logic                 is_call;
        logic                 is_ret;
    } bpu_update_t;

endpackage

// ==== source/exu_stage_reg.sv ====
// decode to execute pipeline register with stall hold and flush masking
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_stage_reg
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    stall,
    input  logic    flush,
    input  logic    id_valid,
    input  ex_uop_t id_uop,
    output logic    ex_valid,
    output ex_uop_t ex_uop,
    output logic    lsu_valid
);

    // a strobe at a stalled edge is dropped, the held entry stays
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
            ex_uop   <= '0;
        end else if (!stall) begin
            ex_valid <= id_valid;
            ex_uop   <= id_uop;
        end
    end

    // flush kills the instruction for this cycle only
    assign lsu_valid = ex_valid & ~flush;

endmodule

// ==== source/exu_forward.sv ====
// operand bypass from the memory and writeback stages
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_forward
    import exu_pkg::*;
(
    input  ex_uop_t              ex_uop,
    input  bypass_t              lsu_bypass,
    input  bypass_t              wb_bypass,
    output logic [`EXU_XLEN-1:0] op_a,
    output logic [`EXU_XLEN-1:0] op_b
);

    logic lsu_fwd_ok;
    logic wb_fwd_ok;
    logic lsu_hit_rs1, lsu_hit_rs2;
    logic wb_hit_rs1, wb_hit_rs2;

    // a port only counts when it writes a real register
    assign lsu_fwd_ok = lsu_bypass.we && (lsu_bypass.rd != `EXU_ZERO_REG);
    assign wb_fwd_ok  = wb_bypass.we && (wb_bypass.rd != `EXU_ZERO_REG);

    assign lsu_hit_rs1 = lsu_fwd_ok && (lsu_bypass.rd == ex_uop.rs1);
    assign lsu_hit_rs2 = lsu_fwd_ok && (lsu_bypass.rd == ex_uop.rs2);
    assign wb_hit_rs1  = wb_fwd_ok && (wb_bypass.rd == ex_uop.rs1);
    assign wb_hit_rs2  = wb_fwd_ok && (wb_bypass.rd == ex_uop.rs2);

    // memory stage is younger, so it wins over writeback
    assign op_a = lsu_hit_rs1 ? lsu_bypass.data :
                  wb_hit_rs1  ? wb_bypass.data  :
                                ex_uop.rd1;

    assign op_b = lsu_hit_rs2 ? lsu_bypass.data :
                  wb_hit_rs2  ? wb_bypass.data  :
                                ex_uop.rd2;

endmodule

// ==== source/exu_datapath.sv ====
// operand select, ALU with branch compare and result select
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_datapath
    import exu_pkg::*;
(
    input  ex_uop_t              ex_uop,
    input  logic [`EXU_XLEN-1:0] op_a,
    input  logic [`EXU_XLEN-1:0] op_b,
    output logic [`EXU_XLEN-1:0] alu_out,
    output logic [`EXU_XLEN-1:0] pc_imm,
    output logic                 cmp_true,
    output lsu_req_t             lsu_req
);

    logic [`EXU_XLEN-1:0] op2;
    logic [4:0]           shamt;
    logic                 lt_s;
    logic                 lt_u;
    logic [`EXU_XLEN-1:0] dout;

    assign op2   = ex_uop.ctrl.op2_imm ? ex_uop.imm : op_b;
    assign shamt = op2[4:0];
    assign lt_s  = $signed(op_a) < $signed(op2);
    assign lt_u  = op_a < op2;

    always_comb begin
        alu_out  = op_a + op2;
        cmp_true = 1'b0;
        case (ex_uop.ctrl.alu_op)
            alu_add:  alu_out = op_a + op2;
            alu_sub:  alu_out = op_a - op2;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            alu_sltu: alu_out = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            alu_xor:  alu_out = op_a ^ op2;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $signed(op_a) >>> shamt;
            alu_or:   alu_out = op_a | op2;
            alu_and:  alu_out = op_a & op2;
            // compares keep the sum on alu_out
            alu_eq:   cmp_true = (op_a == op2);
            alu_ne:   cmp_true = (op_a != op2);
            alu_lt:   cmp_true = lt_s;
            alu_ge:   cmp_true = ~lt_s;
            alu_ltu:  cmp_true = lt_u;
            alu_geu:  cmp_true = ~lt_u;
            default:  alu_out = op_a + op2;
        endcase
    end

    // branch and jal target, also auipc result
    assign pc_imm = ex_uop.pc + ex_uop.imm;

    always_comb begin
        case (ex_uop.ctrl.rd_sel)
            sel_alu:     dout = alu_out;
            sel_pc_imm:  dout = pc_imm;
            sel_pc_plus: dout = ex_uop.pc_plus;
            sel_imm:     dout = ex_uop.imm;
            default:     dout = alu_out;
        endcase
    end

    assign lsu_req.pc         = ex_uop.pc;
    assign lsu_req.rd         = ex_uop.rd;
    assign lsu_req.rf_we      = ex_uop.ctrl.rf_we;
    assign lsu_req.mem_we     = ex_uop.ctrl.mem_we;
    assign lsu_req.mem_re     = ex_uop.ctrl.mem_re;
    assign lsu_req.mem_size   = ex_uop.ctrl.mem_size;
    assign lsu_req.dout       = dout;
    // store data takes the bypassed rs2, not the immediate
    assign lsu_req.store_data = op_b;

endmodule

// ==== source/exu_branch.sv ====
// branch and jump resolution, fetch redirect and predictor update
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_branch
    import exu_pkg::*;
(
    input  logic                 ex_valid,
    input  logic                 flush,
    input  ex_uop_t              ex_uop,
    input  logic [`EXU_XLEN-1:0] alu_out,
    input  logic [`EXU_XLEN-1:0] pc_imm,
    input  logic                 cmp_true,
    output redirect_t            redirect,
    output bpu_update_t          bpu_update
);

    logic                 live;
    logic [`EXU_XLEN-1:0] jalr_target;
    logic                 br_miss;
    logic                 jal_miss;
    logic                 jalr_miss;
    logic                 mispredict;
    logic                 rd_link;
    logic                 rs1_link;

    assign live = ex_valid & ~flush;

    // jalr clears bit 0 of the computed address
    assign jalr_target = {alu_out[`EXU_XLEN-1:1], 1'b0};

    assign br_miss   = ex_uop.ctrl.is_branch && (cmp_true != ex_uop.bp_taken);
    assign jal_miss  = ex_uop.ctrl.is_jal && !ex_uop.bp_taken;
    assign jalr_miss = ex_uop.ctrl.is_jalr &&
                       (!ex_uop.bp_taken || (ex_uop.bp_target != jalr_target));
    assign mispredict = br_miss | jal_miss | jalr_miss;

    // a wrong taken guess falls back to the next sequential pc
    assign redirect.valid = live && mispredict;
    assign redirect.pc    = ex_uop.ctrl.is_jalr ? jalr_target    :
                            ex_uop.bp_taken     ? ex_uop.pc_plus :
                                                  pc_imm;

    // x1 and x5 are the link registers for the return stack
    assign rd_link  = (ex_uop.rd == `EXU_LINK_RA) || (ex_uop.rd == `EXU_LINK_T0);
    assign rs1_link = (ex_uop.rs1 == `EXU_LINK_RA) || (ex_uop.rs1 == `EXU_LINK_T0);

    assign bpu_update.valid     = live && (ex_uop.ctrl.is_branch ||
                                           ex_uop.ctrl.is_jal ||
                                           ex_uop.ctrl.is_jalr);
    assign bpu_update.new_entry = ~ex_uop.bp_match;
    assign bpu_update.pc        = ex_uop.pc;
    assign bpu_update.target    = pc_imm;
    assign bpu_update.taken     = ex_uop.ctrl.is_jal || ex_uop.ctrl.is_jalr ||
                                  (ex_uop.ctrl.is_branch && cmp_true);
    assign bpu_update.is_call   = ex_uop.ctrl.is_jal && rd_link;
    assign bpu_update.is_ret    = ex_uop.ctrl.is_jalr && !rd_link && rs1_link;

endmodule

// ==== source/exu_top.sv ====
// integer execute stage of the in-order pipeline
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        id_valid,
    input  ex_uop_t     id_uop,
    input  bypass_t     lsu_bypass,
    input  bypass_t     wb_bypass,
    input  logic        stall,
    input  logic        flush,
    output logic        lsu_valid,
    output lsu_req_t    lsu_req,
    output redirect_t   redirect,
    output bpu_update_t bpu_update
);

    logic                 ex_valid;
    ex_uop_t              ex_uop;
    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;
    logic [`EXU_XLEN-1:0] alu_out;
    logic [`EXU_XLEN-1:0] pc_imm;
    logic                 cmp_true;

    exu_stage_reg u_stage_reg (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .flush     (flush),
        .id_valid  (id_valid),
        .id_uop    (id_uop),
        .ex_valid  (ex_valid),
        .ex_uop    (ex_uop),
        .lsu_valid (lsu_valid)
    );

    exu_forward u_forward (
        .ex_uop     (ex_uop),
        .lsu_bypass (lsu_bypass),
        .wb_bypass  (wb_bypass),
        .op_a       (op_a),
        .op_b       (op_b)
    );

    exu_datapath u_datapath (
        .ex_uop   (ex_uop),
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_out  (alu_out),
        .pc_imm   (pc_imm),
        .cmp_true (cmp_true),
        .lsu_req  (lsu_req)
    );

    exu_branch u_branch (
        .ex_valid   (ex_valid),
        .flush      (flush),
        .ex_uop     (ex_uop),
        .alu_out    (alu_out),
        .pc_imm     (pc_imm),
        .cmp_true   (cmp_true),
        .redirect   (redirect),
        .bpu_update (bpu_update)
    );

endmodule

// ==== tests/exu_sva.sv ====
// execute stage output assertions, bound into the top level
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_sva
    import exu_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        stall,
    input logic        flush,
    input logic        lsu_valid,
    input lsu_req_t    lsu_req,
    input redirect_t   redirect,
    input bpu_update_t bpu_update
);

    // nothing leaves the stage while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !lsu_valid && !redirect.valid && !bpu_update.valid)
        else $error("valid output high during reset");

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rstn)
        flush |-> !lsu_valid && !redirect.valid && !bpu_update.valid)
        else $error("valid output high under flush");

    a_redirect_even: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid |-> !redirect.pc[0])
        else $error("redirect pc has bit 0 set");

    // held entry keeps its pc across a stalled edge
    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(lsu_req.pc))
        else $error("lsu_req pc changed across a stall");

endmodule

// ==== tests/exu_tb.sv ====
// execute stage testbench with seeded random stimulus and a cycle model
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_tb
    import exu_pkg::*;
();

    localparam int N_ALU = 300;
    localparam int N_FWD = 200;
    localparam int N_BR = 300;
    localparam int N_SF = 200;
    localparam int CYCLE_LIMIT = 2 * (1 + N_ALU + N_FWD + N_BR + N_SF) + 100;

    logic        clk = 1'b0;
    logic        rstn;
    logic        id_valid;
    ex_uop_t     id_uop;
    bypass_t     lsu_bypass;
    bypass_t     wb_bypass;
    logic        stall;
    logic        flush;
    logic        lsu_valid;
    lsu_req_t    lsu_req;
    redirect_t   redirect;
    bpu_update_t bpu_update;

    // model copy of the execute register
    logic        m_valid;
    ex_uop_t     m_uop;
    logic [31:0] pc_q[$];
    int          seq = 0;
    int          cycles = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    exu_top exu_top_i (.*);

    bind exu_top exu_sva exu_sva_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic note_fail(input string msg);
        $display("FAIL t=%0t %s", $time, msg);
        n_fail++;
    endtask

    function automatic logic [4:0] random_reg();
        case ($urandom % 4)
            0: return `EXU_ZERO_REG;
            1: return `EXU_LINK_RA;
            2: return `EXU_LINK_T0;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic logic is_link(input logic [4:0] r);
        return (r == `EXU_LINK_RA) || (r == `EXU_LINK_T0);
    endfunction

    // memory stage first, then writeback, x0 never
    function automatic logic [31:0] fwd_value(input logic [4:0] r, input logic [31:0] rf);
        if (lsu_bypass.we && lsu_bypass.rd == r && r != `EXU_ZERO_REG)
            return lsu_bypass.data;
        if (wb_bypass.we && wb_bypass.rd == r && r != `EXU_ZERO_REG)
            return wb_bypass.data;
        return rf;
    endfunction

    // kind 0 alu, 1 forwarding, 2 branch or jump
    task automatic make_uop(input int kind, output ex_uop_t u);
        logic [31:0] r;
        int          j;
        r = $urandom;
        u.pc = {r[31:14], seq[11:0], 2'b00};
        seq++;
        u.pc_plus = u.pc + 32'd4;
        u.rs1 = random_reg();
        u.rs2 = random_reg();
        u.rd = random_reg();
        u.rd1 = $urandom;
        u.rd2 = $urandom;
        u.imm = $urandom;
        u.ctrl = ex_ctrl_t'($urandom);
        u.ctrl.alu_op = alu_op_e'($urandom % 10);
        u.ctrl.is_branch = 1'b0;
        u.ctrl.is_jal = 1'b0;
        u.ctrl.is_jalr = 1'b0;
        u.bp_taken = 1'($urandom);
        u.bp_match = 1'($urandom);
        u.bp_target = $urandom & 32'hffff_fffc;
        if (kind == 1)
            u.ctrl.rd_sel = sel_alu;
        if (kind == 2) begin
            // offsets are even
            u.imm[0] = 1'b0;
            j = $urandom % 3;
            u.ctrl.is_branch = (j == 0);
            u.ctrl.is_jal = (j == 1);
            u.ctrl.is_jalr = (j == 2);
            u.ctrl.op2_imm = (j != 0);
            u.ctrl.rd_sel = sel_pc_plus;
            u.ctrl.alu_op = (j == 0) ? alu_op_e'(10 + $urandom % 6) : alu_add;
            if (j == 0 && $urandom % 3 == 0)
                u.rd2 = u.rd1;
            if (j == 2 && $urandom % 2 == 0)
                u.bp_target = (u.rd1 + u.imm) & 32'hffff_fffe;
        end
    endtask

    // modes 0 to 4 aim the ports at the operands, others are random
    task automatic make_bypass(input int mode, input ex_uop_t t,
                               output bypass_t l, output bypass_t w);
        l = '{we: 1'b1, rd: random_reg(), data: $urandom};
        w = '{we: 1'b1, rd: random_reg(), data: $urandom};
        case (mode)
            0: l.rd = t.rs1;
            1: l.rd = t.rs2;
            2: begin
                l.rd = t.rs1;
                w.rd = t.rs1;
            end
            3: begin
                w.rd = t.rs1;
                l.rd = t.rs2;
            end
            4: begin
                l.rd = `EXU_ZERO_REG;
                w.rd = `EXU_ZERO_REG;
            end
            default: begin
                l.we = 1'($urandom);
                w.we = 1'($urandom);
            end
        endcase
    endtask

    task automatic check_outputs();
        logic [31:0] a, b, op2, res, jt, pc_imm, exp_pc;
        logic [4:0]  sh;
        logic        cmp, live, miss;
        lsu_req_t    el;
        redirect_t   er;
        bpu_update_t eb;
        a = fwd_value(m_uop.rs1, m_uop.rd1);
        b = fwd_value(m_uop.rs2, m_uop.rd2);
        op2 = m_uop.ctrl.op2_imm ? m_uop.imm : b;
        sh = op2[4:0];
        res = a + op2;
        cmp = 1'b0;
        case (m_uop.ctrl.alu_op)
            alu_sub:  res = a - op2;
            alu_sll:  res = a << sh;
            alu_slt:  res = {31'b0, $signed(a) < $signed(op2)};
            alu_sltu: res = {31'b0, a < op2};
            alu_xor:  res = a ^ op2;
            alu_srl:  res = a >> sh;
            // sign fill of the vacated top bits
            alu_sra:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            alu_or:   res = a | op2;
            alu_and:  res = a & op2;
            alu_eq:   cmp = (a == op2);
            alu_ne:   cmp = (a != op2);
            alu_lt:   cmp = ($signed(a) < $signed(op2));
            alu_ge:   cmp = !($signed(a) < $signed(op2));
            alu_ltu:  cmp = (a < op2);
            alu_geu:  cmp = (a >= op2);
            default:  res = a + op2;
        endcase
        pc_imm = m_uop.pc + m_uop.imm;
        el = '{pc: m_uop.pc, rd: m_uop.rd, rf_we: m_uop.ctrl.rf_we,
               mem_we: m_uop.ctrl.mem_we, mem_re: m_uop.ctrl.mem_re,
               mem_size: m_uop.ctrl.mem_size, dout: res, store_data: b};
        case (m_uop.ctrl.rd_sel)
            sel_pc_imm:  el.dout = pc_imm;
            sel_pc_plus: el.dout = m_uop.pc_plus;
            sel_imm:     el.dout = m_uop.imm;
            default:     el.dout = res;
        endcase
        jt = res & 32'hffff_fffe;
        miss = (m_uop.ctrl.is_branch && cmp != m_uop.bp_taken) ||
               (m_uop.ctrl.is_jal && !m_uop.bp_taken) ||
               (m_uop.ctrl.is_jalr && (!m_uop.bp_taken || m_uop.bp_target != jt));
        live = m_valid && !flush;
        er.valid = live && miss;
        er.pc = m_uop.ctrl.is_jalr ? jt : (m_uop.bp_taken ? m_uop.pc_plus : pc_imm);
        eb = '{valid: live && (m_uop.ctrl.is_branch || m_uop.ctrl.is_jal ||
                               m_uop.ctrl.is_jalr),
               new_entry: !m_uop.bp_match, pc: m_uop.pc, target: pc_imm,
               taken: m_uop.ctrl.is_jal || m_uop.ctrl.is_jalr ||
                      (m_uop.ctrl.is_branch && cmp),
               is_call: m_uop.ctrl.is_jal && is_link(m_uop.rd),
               is_ret: m_uop.ctrl.is_jalr && !is_link(m_uop.rd) && is_link(m_uop.rs1)};
        if (lsu_valid !== live)
            note_fail($sformatf("lsu_valid %0b, expected %0b", lsu_valid, live));
        else
            n_pass++;
        if (lsu_req !== el)
            note_fail($sformatf("lsu_req %h, expected %h", lsu_req, el));
        else
            n_pass++;
        if (redirect !== er)
            note_fail($sformatf("redirect %h, expected %h", redirect, er));
        else
            n_pass++;
        if (bpu_update !== eb)
            note_fail($sformatf("bpu_update %h, expected %h", bpu_update, eb));
        else
            n_pass++;
        // an unstalled cycle consumes the oldest accepted instruction
        if (!stall && lsu_valid) begin
            if (pc_q.size() == 0) begin
                note_fail("result consumed with no instruction outstanding");
            end else begin
                exp_pc = pc_q.pop_front();
                if (lsu_req.pc !== exp_pc)
                    note_fail($sformatf("consumed pc %h, expected %h", lsu_req.pc, exp_pc));
            end
        end else if (!stall && flush && m_valid && pc_q.size() != 0) begin
            // a flushed instruction leaves without a result
            void'(pc_q.pop_front());
        end
    endtask

    task automatic run_cycle(input logic v, input ex_uop_t u, input bypass_t l,
                             input bypass_t w, input logic st, input logic fl);
        @(posedge clk);
        if (!stall) begin
            m_valid = id_valid;
            m_uop = id_uop;
        end
        #1;
        id_valid = v;
        id_uop = u;
        lsu_bypass = l;
        wb_bypass = w;
        stall = st;
        flush = fl;
        #1;
        check_outputs();
        // the strobe is taken at the next edge only when stall is low there
        if (v && !st)
            pc_q.push_back(u.pc);
    endtask

    // back to back strobes, bypass aimed at the instruction in execute
    task automatic run_block(input int kind, input int count, input bit aim_fwd);
        ex_uop_t u;
        ex_uop_t prev;
        bypass_t l;
        bypass_t w;
        int      i;
        prev = id_uop;
        for (i = 0; i < count; i++) begin
            make_uop(kind, u);
            make_bypass(aim_fwd ? int'($urandom % 5) : 5, prev, l, w);
            run_cycle(1'b1, u, l, w, 1'b0, 1'b0);
            prev = u;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s done, %0d errors", name, n_fail - fails_before);
    endtask

    initial begin
        ex_uop_t u;
        bypass_t l;
        bypass_t w;
        bypass_t idle_bp;
        int      f0;
        int      issued;
        logic    v;
        void'($urandom(32'h55b9_273e));
        rstn = 1'b0;
        id_valid = 1'b0;
        id_uop = '0;
        lsu_bypass = '0;
        wb_bypass = '0;
        stall = 1'b0;
        flush = 1'b0;
        m_valid = 1'b0;
        m_uop = '0;
        idle_bp = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        f0 = n_fail;
        make_uop(0, u);
        repeat (5) run_cycle(1'b0, u, idle_bp, idle_bp, 1'b0, 1'b0);
        run_cycle(1'b1, u, idle_bp, idle_bp, 1'b0, 1'b0);
        repeat (2) run_cycle(1'b0, u, idle_bp, idle_bp, 1'b0, 1'b0);
        report_test("reset_and_latency", f0);

        f0 = n_fail;
        run_block(0, N_ALU, 1'b0);
        report_test("alu_result_select", f0);
        f0 = n_fail;
        run_block(1, N_FWD, 1'b1);
        report_test("forwarding", f0);
        f0 = n_fail;
        run_block(2, N_BR, 1'b0);
        report_test("branch_resolution", f0);

        f0 = n_fail;
        issued = 0;
        v = 1'b1;
        while (issued < N_SF) begin
            // the strobe stays put until an unstalled edge takes it
            if (!stall) begin
                make_uop($urandom % 3, u);
                v = ($urandom % 5) != 0;
                issued++;
            end
            make_bypass(5, u, l, w);
            run_cycle(v, u, l, w, ($urandom % 4) == 0, ($urandom % 8) == 0);
        end
        repeat (2) run_cycle(1'b0, u, idle_bp, idle_bp, 1'b0, 1'b0);
        if (pc_q.size() != 0)
            note_fail($sformatf("%0d accepted instructions never consumed", pc_q.size()));
        report_test("stall_and_flush", f0);

        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
source/exu_pkg.sv
source/exu_stage_reg.sv
source/exu_forward.sv
source/exu_datapath.sv
source/exu_branch.sv
source/exu_top.sv
tests/exu_sva.sv
tests/exu_tb.sv
